// File: common/cpuPkg.sv
package cpuPkg;

    localparam int DATA_WIDTH = 16;
    localparam int REG_COUNT = 8;
    localparam int DMEM_DEPTH = 256;
    localparam int DMEM_ADDR_WIDTH = $clog2(DMEM_DEPTH);
    localparam int RETURN_REG = 7;

    // Codes 13 to 15 are left unnamed and retire as no-ops
    typedef enum logic [3:0] {
        RTYPE = 4'd0,
        ADDI  = 4'd1,
        ANDI  = 4'd2,
        LW    = 4'd3,
        SW    = 4'd4,
        BEQ   = 4'd5,
        BLT   = 4'd6,
        LUI   = 4'd7,
        LLI   = 4'd8,
        J     = 4'd9,
        JAL   = 4'd10,
        RET   = 4'd11,
        HALT  = 4'd12
    } opcodeE;

    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLT = 3'd5,
        SLL = 3'd6,
        SRL = 3'd7
    } aluFuncE;

    typedef enum logic [1:0] {
        REGFILE,
        FROM_EX,
        FROM_RES
    } forwardE;

    typedef struct packed {
        logic                  valid;
        logic [DATA_WIDTH-1:0] instruction;
        logic [DATA_WIDTH-1:0] npc;
    } fetchT;

    typedef struct packed {
        logic                  valid;
        opcodeE                opcode;
        aluFuncE               func;
        logic [2:0]            rd;
        logic                  writes;
        logic [DATA_WIDTH-1:0] a;
        logic [DATA_WIDTH-1:0] b;
        logic [DATA_WIDTH-1:0] storeData;
        logic [DATA_WIDTH-1:0] imm;
        logic [DATA_WIDTH-1:0] branchTarget;
        logic [DATA_WIDTH-1:0] npc;
    } decodeT;

    typedef struct packed {
        logic                  valid;
        opcodeE                opcode;
        logic [2:0]            rd;
        logic                  writes;
        logic [DATA_WIDTH-1:0] aluOut;
        logic [DATA_WIDTH-1:0] storeData;
    } executeT;

    typedef struct packed {
        logic                  valid;
        logic [2:0]            rd;
        logic [DATA_WIDTH-1:0] data;
    } writebackT;

    typedef struct packed {
        logic                  valid;
        logic [DATA_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
    } storeT;

    // Stores and branches read rd through the second register port
    function automatic logic usesRdSource(input opcodeE op);
        return op inside {SW, BEQ, BLT};
    endfunction

endpackage

// File: hw/regFile.sv
module regFile (
    input  logic              clk,
    input  logic              arstN,
    input  logic [2:0]        raddrA,
    input  logic [2:0]        raddrB,
    input  cpuPkg::writebackT wr,
    output logic [15:0]       rdataA,
    output logic [15:0]       rdataB,
    output logic [15:0]       r7
);

    logic [cpuPkg::DATA_WIDTH-1:0] regs [cpuPkg::REG_COUNT];
    logic writeEn;

    assign writeEn = wr.valid && (wr.rd != 3'd0);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < cpuPkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[wr.rd] <= wr.data;
        end
    end

    // Write-through so a reader in the same cycle sees the new value
    assign rdataA = (writeEn && wr.rd == raddrA) ? wr.data : regs[raddrA];
    assign rdataB = (writeEn && wr.rd == raddrB) ? wr.data : regs[raddrB];
    assign r7 = (writeEn && wr.rd == 3'(cpuPkg::RETURN_REG)) ?
                wr.data : regs[cpuPkg::RETURN_REG];

    // r0 reads as zero on both ports whatever the pipeline retires
    assert property (@(posedge clk) disable iff (!arstN)
        (raddrA == 3'd0) |-> (rdataA == '0))
        else $error("r0 read back nonzero on port A");

    assert property (@(posedge clk) disable iff (!arstN)
        (raddrB == 3'd0) |-> (rdataB == '0))
        else $error("r0 read back nonzero on port B");

endmodule

// File: hw/fetchStage.sv
module fetchStage (
    input  logic          clk,
    input  logic          arstN,
    input  logic          stall,
    input  logic          flush,
    input  logic          redirect,
    input  logic          stop,
    input  logic [15:0]   redirectPc,
    input  logic [15:0]   imemData,
    output logic [15:0]   imemAddr,
    output cpuPkg::fetchT fetchOut
);

    logic [15:0] pc;
    logic stopped;
    logic holdPc;

    assign imemAddr = pc;
    assign holdPc = stall || stopped || stop;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
            stopped <= 1'b0;
            fetchOut <= '0;
        end else begin
            // Redirect wins over any hold
            if (redirect) begin
                pc <= redirectPc;
            end else if (!holdPc) begin
                pc <= pc + 16'd1;
            end

            // A HALT that is being flushed must not stop fetch
            if (stop && !flush) begin
                stopped <= 1'b1;
            end

            if (flush) begin
                fetchOut.valid <= 1'b0;
            end else if (!stall) begin
                fetchOut.valid <= !(stopped || stop);
                fetchOut.instruction <= imemData;
                fetchOut.npc <= pc + 16'd1;
            end
        end
    end

endmodule

// File: hw/hazardUnit.sv
module hazardUnit (
    input  cpuPkg::fetchT   decodeIn,
    input  cpuPkg::decodeT  exStage,
    input  cpuPkg::executeT resStage,
    output cpuPkg::forwardE fwdA,
    output cpuPkg::forwardE fwdB,
    output logic            stall,
    output logic            flushDecode,
    output logic            flushExecute,
    input  logic            jumpTaken,
    input  logic            branchTaken
);

    cpuPkg::opcodeE decOp;
    logic [2:0] srcA;
    logic [2:0] srcB;
    logic exWrites;
    logic resWrites;
    logic loadUse;
    logic retWait;

    // Youngest producer first, then the result stage, then the register file
    function automatic cpuPkg::forwardE pickSource(input logic [2:0] src);
        if (exWrites && exStage.opcode != cpuPkg::LW && exStage.rd == src) begin
            return cpuPkg::FROM_EX;
        end else if (resWrites && resStage.rd == src) begin
            return cpuPkg::FROM_RES;
        end
        return cpuPkg::REGFILE;
    endfunction

    assign decOp = cpuPkg::opcodeE'(decodeIn.instruction[15:12]);
    assign srcA = decodeIn.instruction[8:6];
    assign srcB = cpuPkg::usesRdSource(decOp) ? decodeIn.instruction[11:9] :
                  decodeIn.instruction[5:3];

    assign exWrites = exStage.valid && exStage.writes;
    assign resWrites = resStage.valid && resStage.writes;

    always_comb begin
        fwdA = pickSource(srcA);
        fwdB = pickSource(srcB);
    end

    assign loadUse = decodeIn.valid && exWrites && exStage.opcode == cpuPkg::LW &&
                     (exStage.rd == srcA || exStage.rd == srcB);

    // RET reads r7 straight from the register file
    assign retWait = decodeIn.valid && decOp == cpuPkg::RET &&
                     ((exWrites && exStage.rd == 3'(cpuPkg::RETURN_REG)) ||
                      (resWrites && resStage.rd == 3'(cpuPkg::RETURN_REG)));

    // A taken branch discards decode, so there is nothing left to hold
    assign stall = (loadUse || retWait) && !branchTaken;
    assign flushDecode = jumpTaken || branchTaken;
    assign flushExecute = branchTaken;

    always_comb begin
        assert final (!(stall && (flushDecode || flushExecute)))
            else $error("Stall and flush requested for the same pipeline register");
    end

endmodule

// File: decode/decodeStage.sv
module decodeStage (
    input  logic              clk,
    input  logic              arstN,
    input  cpuPkg::fetchT     fetchIn,
    input  logic              stall,
    input  logic              flush,
    input  cpuPkg::forwardE   fwdA,
    input  cpuPkg::forwardE   fwdB,
    input  logic [15:0]       exForward,
    input  cpuPkg::writebackT resForward,
    input  logic [15:0]       rdataA,
    input  logic [15:0]       rdataB,
    input  logic [15:0]       r7,
    output logic [2:0]        raddrA,
    output logic [2:0]        raddrB,
    output logic              jumpTaken,
    output logic              haltSeen,
    output logic [15:0]       jumpTarget,
    output cpuPkg::decodeT    decodeOut
);

    cpuPkg::opcodeE opcode;
    logic [2:0] rdField;
    logic [2:0] rs1Field;
    logic [2:0] rs2Field;
    logic [5:0] imm6;
    logic [7:0] imm8;
    logic knownOp;
    logic writesReg;
    logic isJump;
    logic [15:0] immExt;
    logic [15:0] opA;
    logic [15:0] opB;
    cpuPkg::decodeT nextDecode;

    function automatic logic [15:0] selectOperand(input cpuPkg::forwardE sel,
                                                  input logic [15:0] regValue);
        case (sel)
            cpuPkg::FROM_EX: return exForward;
            cpuPkg::FROM_RES: return resForward.data;
            default: return regValue;
        endcase
    endfunction

    assign opcode = cpuPkg::opcodeE'(fetchIn.instruction[15:12]);
    assign rdField = fetchIn.instruction[11:9];
    assign rs1Field = fetchIn.instruction[8:6];
    assign rs2Field = fetchIn.instruction[5:3];
    assign imm6 = fetchIn.instruction[5:0];
    assign imm8 = fetchIn.instruction[7:0];
    assign knownOp = fetchIn.instruction[15:12] <= 4'(cpuPkg::HALT);

    assign raddrA = rs1Field;
    assign raddrB = cpuPkg::usesRdSource(opcode) ? rdField : rs2Field;

    always_comb begin
        case (opcode)
            cpuPkg::ANDI: immExt = {10'd0, imm6};
            cpuPkg::LUI: immExt = {imm8, 8'd0};
            cpuPkg::LLI: immExt = {8'd0, imm8};
            default: immExt = {{10{imm6[5]}}, imm6};
        endcase
    end

    // r0 destinations are dropped here so nothing downstream forwards them
    always_comb begin
        case (opcode)
            cpuPkg::RTYPE, cpuPkg::ADDI, cpuPkg::ANDI,
            cpuPkg::LW, cpuPkg::LUI, cpuPkg::LLI: writesReg = rdField != 3'd0;
            cpuPkg::JAL: writesReg = 1'b1;
            default: writesReg = 1'b0;
        endcase
    end

    always_comb begin
        opA = selectOperand(fwdA, rdataA);
        opB = selectOperand(fwdB, rdataB);
    end

    assign isJump = opcode inside {cpuPkg::J, cpuPkg::JAL, cpuPkg::RET};
    assign jumpTaken = fetchIn.valid && isJump && !stall && !flush;
    assign jumpTarget = (opcode == cpuPkg::RET) ? r7 :
                        {fetchIn.npc[15:12], fetchIn.instruction[11:0]};
    assign haltSeen = fetchIn.valid && opcode == cpuPkg::HALT;

    assign nextDecode = '{
        valid: fetchIn.valid && knownOp,
        opcode: opcode,
        func: cpuPkg::aluFuncE'(fetchIn.instruction[2:0]),
        rd: (opcode == cpuPkg::JAL) ? 3'(cpuPkg::RETURN_REG) : rdField,
        writes: fetchIn.valid && knownOp && writesReg,
        a: opA,
        b: opB,
        storeData: opB,
        imm: immExt,
        branchTarget: immExt + fetchIn.npc,
        npc: fetchIn.npc
    };

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            decodeOut <= '0;
        end else if (stall || flush) begin
            // Bubble, operands keep their last value
            decodeOut.valid <= 1'b0;
            decodeOut.writes <= 1'b0;
        end else begin
            decodeOut <= nextDecode;
        end
    end

    assert property (@(posedge clk) disable iff (!arstN)
        decodeOut.valid |-> (decodeOut.opcode <= cpuPkg::HALT))
        else $error("Unknown opcode %0d issued to execute", decodeOut.opcode);

endmodule

// File: execute/executeStage.sv
module executeStage (
    input  logic            clk,
    input  logic            arstN,
    input  cpuPkg::decodeT  exIn,
    output logic [15:0]     aluResult,
    output logic            branchTaken,
    output logic [15:0]     branchTarget,
    output cpuPkg::executeT executeOut
);

    logic [15:0] opB;
    logic equal;
    logic lessSigned;
    logic [3:0] shamt;

    // Register operand only for RTYPE, every other opcode uses the immediate
    assign opB = (exIn.opcode == cpuPkg::RTYPE) ? exIn.b : exIn.imm;
    assign shamt = opB[3:0];

    // Same compare serves SLT and the branches
    assign equal = exIn.a == exIn.b;
    assign lessSigned = $signed(exIn.a) < $signed(exIn.b);

    always_comb begin
        case (exIn.opcode)
            cpuPkg::RTYPE: begin
                case (exIn.func)
                    cpuPkg::ADD: aluResult = exIn.a + opB;
                    cpuPkg::SUB: aluResult = exIn.a - opB;
                    cpuPkg::AND: aluResult = exIn.a & opB;
                    cpuPkg::OR: aluResult = exIn.a | opB;
                    cpuPkg::XOR: aluResult = exIn.a ^ opB;
                    cpuPkg::SLT: aluResult = {15'd0, lessSigned};
                    cpuPkg::SLL: aluResult = exIn.a << shamt;
                    default: aluResult = exIn.a >> shamt;
                endcase
            end
            cpuPkg::ADDI, cpuPkg::LW, cpuPkg::SW: aluResult = exIn.a + opB;
            cpuPkg::ANDI: aluResult = exIn.a & opB;
            cpuPkg::LUI, cpuPkg::LLI: aluResult = exIn.imm;
            // Return address for the link register
            cpuPkg::JAL: aluResult = exIn.npc;
            default: aluResult = '0;
        endcase
    end

    assign branchTaken = exIn.valid &&
                         ((exIn.opcode == cpuPkg::BEQ && equal) ||
                          (exIn.opcode == cpuPkg::BLT && lessSigned));
    assign branchTarget = exIn.branchTarget;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            executeOut <= '0;
        end else begin
            executeOut <= '{
                valid: exIn.valid,
                opcode: exIn.opcode,
                rd: exIn.rd,
                writes: exIn.writes,
                aluOut: aluResult,
                storeData: exIn.storeData
            };
        end
    end

endmodule

// File: result/resultStage.sv
module resultStage (
    input  logic              clk,
    input  logic              arstN,
    input  cpuPkg::executeT   resIn,
    output cpuPkg::writebackT wb,
    output cpuPkg::storeT     store,
    output logic              halted
);

    logic [cpuPkg::DATA_WIDTH-1:0] dmem [cpuPkg::DMEM_DEPTH];
    logic [cpuPkg::DMEM_ADDR_WIDTH-1:0] memIndex;
    logic [15:0] loadData;

    assign memIndex = resIn.aluOut[cpuPkg::DMEM_ADDR_WIDTH-1:0];
    assign loadData = dmem[memIndex];

    assign store.valid = resIn.valid && resIn.opcode == cpuPkg::SW;
    assign store.addr = resIn.aluOut;
    assign store.data = resIn.storeData;

    // The writes flag is already false for r0 destinations
    assign wb.valid = resIn.valid && resIn.writes;
    assign wb.rd = resIn.rd;
    assign wb.data = (resIn.opcode == cpuPkg::LW) ? loadData : resIn.aluOut;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < cpuPkg::DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (store.valid) begin
            dmem[memIndex] <= store.data;
        end
    end

    // Sticky until the next reset
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            halted <= 1'b0;
        end else if (resIn.valid && resIn.opcode == cpuPkg::HALT) begin
            halted <= 1'b1;
        end
    end

endmodule

// File: hw/cpuTop.sv
module cpuTop (
    input  logic              clk,
    input  logic              arstN,
    input  logic [15:0]       imemData,
    output logic [15:0]       imemAddr,
    output cpuPkg::writebackT wb,
    output cpuPkg::storeT     store,
    output logic              halted
);

    cpuPkg::fetchT fetchReg;
    cpuPkg::decodeT decodeReg;
    cpuPkg::executeT executeReg;
    cpuPkg::forwardE fwdA;
    cpuPkg::forwardE fwdB;
    logic stall;
    logic flushDecode;
    logic flushExecute;
    logic jumpTaken;
    logic haltSeen;
    logic branchTaken;
    logic [15:0] jumpTarget;
    logic [15:0] branchTarget;
    logic [15:0] aluResult;
    logic [15:0] rdataA;
    logic [15:0] rdataB;
    logic [15:0] r7;
    logic [2:0] raddrA;
    logic [2:0] raddrB;
    logic redirect;
    logic [15:0] redirectPc;

    // The branch in execute is older than any jump in decode
    assign redirect = branchTaken || jumpTaken;
    assign redirectPc = branchTaken ? branchTarget : jumpTarget;

    fetchStage fetchStage_inst (
        .clk(clk), .arstN(arstN), .stall(stall), .flush(flushDecode),
        .redirect(redirect), .stop(haltSeen), .redirectPc(redirectPc),
        .imemData(imemData), .imemAddr(imemAddr), .fetchOut(fetchReg)
    );

    decodeStage decodeStage_inst (
        .clk(clk), .arstN(arstN), .fetchIn(fetchReg), .stall(stall),
        .flush(flushExecute), .fwdA(fwdA), .fwdB(fwdB), .exForward(aluResult),
        .resForward(wb), .rdataA(rdataA), .rdataB(rdataB), .r7(r7),
        .raddrA(raddrA), .raddrB(raddrB), .jumpTaken(jumpTaken),
        .haltSeen(haltSeen), .jumpTarget(jumpTarget), .decodeOut(decodeReg)
    );

    executeStage executeStage_inst (
        .clk(clk), .arstN(arstN), .exIn(decodeReg), .aluResult(aluResult),
        .branchTaken(branchTaken), .branchTarget(branchTarget),
        .executeOut(executeReg)
    );

    resultStage resultStage_inst (
        .clk(clk), .arstN(arstN), .resIn(executeReg), .wb(wb),
        .store(store), .halted(halted)
    );

    regFile regFile_inst (
        .clk(clk), .arstN(arstN), .raddrA(raddrA), .raddrB(raddrB),
        .wr(wb), .rdataA(rdataA), .rdataB(rdataB), .r7(r7)
    );

    hazardUnit hazardUnit_inst (
        .decodeIn(fetchReg), .exStage(decodeReg), .resStage(executeReg),
        .fwdA(fwdA), .fwdB(fwdB), .stall(stall), .flushDecode(flushDecode),
        .flushExecute(flushExecute), .jumpTaken(jumpTaken),
        .branchTaken(branchTaken)
    );

endmodule

// File: verification/clockGen.sv
module clockGen (
    input  logic restart,
    output logic clk,
    output logic arstN
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam time HALF_PERIOD = 50ns;
    localparam time DRIVE_DELAY = 10ns;
    localparam int RESET_CYCLES = 5;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Reset at time zero, then again for every restart request
    initial begin
        arstN = 1'b0;
        forever begin
            repeat (RESET_CYCLES) @(posedge clk);
            #DRIVE_DELAY arstN = 1'b1;
            @(posedge restart);
            @(posedge clk);
            #DRIVE_DELAY arstN = 1'b0;
        end
    end

endmodule

// File: verification/cpuTb.sv
module cpuTb;
    timeunit 1ns;
    timeprecision 100ps;

    typedef enum int {ARITH, HAZARDS, MEMORY, CONTROL, CALL_RETURN} testKindE;

    localparam int PROGRAM_COUNT = 21;
    localparam int MAX_INSTR = 60;
    localparam int CYCLE_LIMIT = PROGRAM_COUNT * (MAX_INSTR * 4 + 30);
    localparam int MODEL_STEP_LIMIT = 1000;
    localparam time DRIVE_DELAY = 10ns;

    logic clk;
    logic arstN;
    logic restart;
    logic [15:0] imemData;
    logic [15:0] imemAddr;
    cpuPkg::writebackT wb;
    cpuPkg::storeT store;
    logic halted;

    logic [15:0] imem [256];
    logic [18:0] expWb [$];
    logic [31:0] expStore [$];
    string testName;
    int wbIdx;
    int storeIdx;
    int cycleCount = 0;

    clockGen clockGen_inst (.restart(restart), .clk(clk), .arstN(arstN));

    cpuTop cpuTop_inst (
        .clk(clk), .arstN(arstN), .imemData(imemData), .imemAddr(imemAddr),
        .wb(wb), .store(store), .halted(halted)
    );

    // Instruction memory answers in the same cycle
    assign imemData = imem[imemAddr[7:0]];

    task automatic stopRun(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "Stopped at the first failing check");
    endtask

    function automatic int pick(input int n);
        return $urandom % n;
    endfunction

    function automatic logic [15:0] encI(input logic [3:0] op, input int rd, input int rs1,
                                         input int low6);
        return {op, 3'(rd), 3'(rs1), 6'(low6)};
    endfunction

    function automatic logic [15:0] encU(input logic [3:0] op, input int rd, input int imm8);
        return {op, 3'(rd), 1'b0, 8'(imm8)};
    endfunction

    function automatic logic [15:0] randArith(input int span);
        int rd;
        int rs1;
        rd = pick(span);
        rs1 = pick(span);
        case (pick(6))
            0, 1: return encI(cpuPkg::RTYPE, rd, rs1, pick(span) * 8 + pick(8));
            2: return encI(cpuPkg::ADDI, rd, rs1, pick(64));
            3: return encI(cpuPkg::ANDI, rd, rs1, pick(64));
            4: return encU(cpuPkg::LUI, rd, pick(256));
            default: return encU(cpuPkg::LLI, rd, pick(256));
        endcase
    endfunction

    function automatic logic [15:0] randMem(input int span);
        if (pick(2) == 0) begin
            return encI(cpuPkg::LW, pick(span), pick(span), pick(8));
        end
        return encI(cpuPkg::SW, pick(span), pick(span), pick(8));
    endfunction

    // Unused words decode as no-ops and carry their own address
    task automatic clearImem();
        for (int i = 0; i < 256; i++) begin
            imem[i] = {4'hD, 4'h0, 8'(i)};
        end
    endtask

    task automatic buildCallReturn();
        int pre;
        int sub;
        pre = 1 + pick(5);
        sub = pre + 6;
        for (int i = 0; i < pre; i++) begin
            imem[i] = randArith(8);
        end
        imem[pre] = {4'(cpuPkg::JAL), 12'(sub)};
        // Skipped because the subroutine bumps the return address
        imem[pre + 1] = encI(cpuPkg::ADDI, 1, 0, 5);
        imem[pre + 2] = encI(cpuPkg::RTYPE, 2, 7, 8 + cpuPkg::ADD);
        imem[pre + 3] = randArith(8);
        imem[pre + 4] = encI(cpuPkg::SW, 2, 0, 9);
        imem[pre + 5] = {4'(cpuPkg::HALT), 12'd0};
        imem[sub] = encI(cpuPkg::ADDI, 3, 7, 2);
        imem[sub + 1] = encI(cpuPkg::SW, 7, 0, 3);
        imem[sub + 2] = encI(cpuPkg::ADDI, 7, 7, 1);
        imem[sub + 3] = {4'(cpuPkg::RET), 12'd0};
    endtask

    task automatic buildProgram(input testKindE kind);
        int n;
        int room;
        int ld;
        int c;
        clearImem();
        if (kind == CALL_RETURN) begin
            buildCallReturn();
            return;
        end
        n = 20 + pick(MAX_INSTR - 19);
        for (int i = 0; i < n; i++) begin
            // HALT sits at index n, so targets never pass it
            room = n - i - 1;
            c = pick(8);
            case (kind)
                ARITH: imem[i] = randArith(8);
                HAZARDS: begin
                    if (c == 0 && i + 1 < n) begin
                        ld = 1 + pick(3);
                        imem[i] = encI(cpuPkg::LW, ld, pick(4), pick(8));
                        imem[i + 1] = encI(cpuPkg::RTYPE, pick(4), ld, ld * 8 + pick(8));
                        i++;
                    end else if (c < 3) begin
                        imem[i] = randMem(4);
                    end else begin
                        imem[i] = randArith(4);
                    end
                end
                MEMORY: imem[i] = (c < 5) ? randMem(4) : randArith(4);
                default: begin
                    if (c == 0) begin
                        imem[i] = encI(cpuPkg::BEQ, pick(4), pick(4),
                                       pick((room > 31 ? 31 : room) + 1));
                    end else if (c == 1) begin
                        imem[i] = encI(cpuPkg::BLT, pick(4), pick(4),
                                       pick((room > 31 ? 31 : room) + 1));
                    end else if (c == 2) begin
                        imem[i] = {4'(cpuPkg::J), 12'(i + 1 + pick(room + 1))};
                    end else begin
                        imem[i] = randArith(4);
                    end
                end
            endcase
        end
        imem[n] = {4'(cpuPkg::HALT), 12'd0};
    endtask

    function automatic logic [15:0] aluRef(input logic [2:0] func, input logic [15:0] a,
                                           input logic [15:0] b);
        case (func)
            3'd0: return a + b;
            3'd1: return a - b;
            3'd2: return a & b;
            3'd3: return a | b;
            3'd4: return a ^ b;
            3'd5: return {15'd0, $signed(a) < $signed(b)};
            3'd6: return a << b[3:0];
            default: return a >> b[3:0];
        endcase
    endfunction

    // Instruction-level ISA model, fills the expected writes and stores
    task automatic runModel();
        logic [15:0] regs [8];
        logic [15:0] mem [256];
        logic [15:0] pc;
        logic [15:0] instr;
        logic [15:0] npc;
        logic [15:0] a;
        logic [15:0] sImm;
        logic [15:0] addr;
        logic [15:0] value;
        logic [2:0] rd;
        logic writes;
        logic done;
        int steps;
        expWb.delete();
        expStore.delete();
        for (int i = 0; i < 8; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            mem[i] = '0;
        end
        pc = '0;
        done = 1'b0;
        steps = 0;
        while (!done) begin
            instr = imem[pc[7:0]];
            npc = pc + 16'd1;
            rd = instr[11:9];
            a = regs[instr[8:6]];
            sImm = {{10{instr[5]}}, instr[5:0]};
            addr = a + sImm;
            writes = 1'b1;
            value = '0;
            pc = npc;
            case (instr[15:12])
                cpuPkg::RTYPE: value = aluRef(instr[2:0], a, regs[instr[5:3]]);
                cpuPkg::ADDI: value = addr;
                cpuPkg::ANDI: value = a & {10'd0, instr[5:0]};
                cpuPkg::LW: value = mem[addr[7:0]];
                cpuPkg::LUI: value = {instr[7:0], 8'd0};
                cpuPkg::LLI: value = {8'd0, instr[7:0]};
                cpuPkg::JAL: begin
                    rd = 3'd7;
                    value = npc;
                    pc = {npc[15:12], instr[11:0]};
                end
                default: begin
                    writes = 1'b0;
                    case (instr[15:12])
                        cpuPkg::SW: begin
                            mem[addr[7:0]] = regs[rd];
                            expStore.push_back({addr, regs[rd]});
                        end
                        cpuPkg::BEQ: if (a == regs[rd]) pc = npc + sImm;
                        cpuPkg::BLT: if ($signed(a) < $signed(regs[rd])) pc = npc + sImm;
                        cpuPkg::J: pc = {npc[15:12], instr[11:0]};
                        cpuPkg::RET: pc = regs[7];
                        cpuPkg::HALT: done = 1'b1;
                        default: ;
                    endcase
                end
            endcase
            if (writes && rd != 3'd0) begin
                regs[rd] = value;
                expWb.push_back({rd, value});
            end
            steps++;
            assert (steps < MODEL_STEP_LIMIT)
                else stopRun($sformatf("%s: reference model never reached HALT", testName));
        end
    endtask

    task automatic checkPulses();
        if (wb.valid) begin
            assert (wb.rd != 3'd0)
                else stopRun($sformatf("%s: a write to r0 appeared on wb", testName));
            assert (wbIdx < expWb.size())
                else stopRun($sformatf("%s: register write to r%0d after all expected writes",
                                       testName, wb.rd));
            assert ({wb.rd, wb.data} == expWb[wbIdx])
                else stopRun($sformatf("** Error %s: write %0d expected r%0d=%h, actual r%0d=%h",
                                       testName, wbIdx, expWb[wbIdx][18:16],
                                       expWb[wbIdx][15:0], wb.rd, wb.data));
            wbIdx++;
        end
        if (store.valid) begin
            assert (storeIdx < expStore.size())
                else stopRun($sformatf("%s: store to %h after all expected stores",
                                       testName, store.addr));
            assert ({store.addr, store.data} == expStore[storeIdx])
                else stopRun($sformatf("** Error %s: store %0d expected [%h]=%h, actual [%h]=%h",
                                       testName, storeIdx, expStore[storeIdx][31:16],
                                       expStore[storeIdx][15:0], store.addr, store.data));
            storeIdx++;
        end
    endtask

    task automatic runProgram(input string name, input testKindE kind);
        logic done;
        testName = name;
        @(posedge clk);
        #DRIVE_DELAY restart = 1'b1;
        @(negedge arstN);
        restart = 1'b0;
        buildProgram(kind);
        runModel();
        wbIdx = 0;
        storeIdx = 0;
        @(posedge arstN);
        done = 1'b0;
        // Outputs are sampled mid-cycle where they are settled
        while (!done) begin
            @(negedge clk);
            checkPulses();
            done = halted;
        end
        assert (wbIdx == expWb.size() && storeIdx == expStore.size())
            else stopRun($sformatf("%s: halted rose after %0d of %0d writes and %0d of %0d stores",
                                   testName, wbIdx, expWb.size(), storeIdx, expStore.size()));
        repeat (10) begin
            @(negedge clk);
            checkPulses();
        end
        assert (halted)
            else stopRun($sformatf("%s: halted dropped without a reset", testName));
    endtask

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > CYCLE_LIMIT) begin
            stopRun($sformatf("Timeout after %0d cycles in %s", CYCLE_LIMIT, testName));
        end
    end

    initial begin
        void'($urandom(32'h9ed4c617));
        restart = 1'b0;
        testName = "reset";
        clearImem();
        @(posedge arstN);
        repeat (4) runProgram("arith", ARITH);
        repeat (4) runProgram("hazards", HAZARDS);
        repeat (4) runProgram("memory", MEMORY);
        repeat (6) runProgram("control", CONTROL);
        repeat (3) runProgram("callReturn", CALL_RETURN);
        $display("No errors");
        $finish;
    end

endmodule

// File: sources.f
common/cpuPkg.sv
hw/regFile.sv
hw/fetchStage.sv
hw/hazardUnit.sv
decode/decodeStage.sv
execute/executeStage.sv
result/resultStage.sv
hw/cpuTop.sv
verification/clockGen.sv
verification/cpuTb.sv
